/* verilog/avmm_pkg.sv */
package avmm_pkg;

    // Bus geometry shared by both sides of the bridge
    localparam int ADDR_WIDTH = 10;
    localparam int DATA_WIDTH = 32;
    localparam int N_BYTES = DATA_WIDTH / 8;
    // Three bits are enough for bursts of one to four beats
    localparam int BURST_CNT_WIDTH = 3;

    // Words actually backed by storage in the memory slave
    localparam int MEM_DEPTH = 512;
    localparam int MEM_ADDR_WIDTH = $clog2(MEM_DEPTH);

    // Avalon response encodings
    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // A read request as it waits in the read queue
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] address;
        logic [BURST_CNT_WIDTH-1:0] burstcount;
        logic [N_BYTES-1:0] byteenable;
    } rd_req_t;

    // One write beat, tagged with eop when it closes its burst
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] address;
        logic [BURST_CNT_WIDTH-1:0] burstcount;
        logic [DATA_WIDTH-1:0] data;
        logic [N_BYTES-1:0] byteenable;
        logic eop;
    } wr_req_t;

endpackage

/* verilog/avmm_rdwr_if.sv */
`timescale 1ns/1ps

// Split Avalon bus with independent read and write request channels
interface avmm_rdwr_if
    import avmm_pkg::*;
();

    // Read channel
    logic rd_read;
    logic [ADDR_WIDTH-1:0] rd_address;
    logic [BURST_CNT_WIDTH-1:0] rd_burstcount;
    logic [N_BYTES-1:0] rd_byteenable;
    logic rd_waitrequest;
    logic [DATA_WIDTH-1:0] rd_readdata;
    logic rd_readdatavalid;
    logic [1:0] rd_response;

    // Write channel
    logic wr_write;
    logic [ADDR_WIDTH-1:0] wr_address;
    logic [BURST_CNT_WIDTH-1:0] wr_burstcount;
    logic [DATA_WIDTH-1:0] wr_writedata;
    logic [N_BYTES-1:0] wr_byteenable;
    logic wr_waitrequest;
    logic wr_writeresponsevalid;
    logic [1:0] wr_response;

    // The master issues requests and sees back-pressure and responses
    modport master (
        output rd_read, rd_address, rd_burstcount, rd_byteenable,
        input rd_waitrequest, rd_readdata, rd_readdatavalid, rd_response,
        output wr_write, wr_address, wr_burstcount, wr_writedata, wr_byteenable,
        input wr_waitrequest, wr_writeresponsevalid, wr_response
    );

    modport slave (
        input rd_read, rd_address, rd_burstcount, rd_byteenable,
        output rd_waitrequest, rd_readdata, rd_readdatavalid, rd_response,
        input wr_write, wr_address, wr_burstcount, wr_writedata, wr_byteenable,
        output wr_waitrequest, wr_writeresponsevalid, wr_response
    );

endinterface

/* verilog/avmm_mem_if.sv */
`timescale 1ns/1ps

// Single shared Avalon bus where reads and writes take turns
interface avmm_mem_if
    import avmm_pkg::*;
();

    logic read;
    logic write;
    logic [ADDR_WIDTH-1:0] address;
    logic [BURST_CNT_WIDTH-1:0] burstcount;
    logic [DATA_WIDTH-1:0] writedata;
    logic [N_BYTES-1:0] byteenable;
    logic waitrequest;
    logic [DATA_WIDTH-1:0] readdata;
    logic readdatavalid;
    logic [1:0] response;
    logic writeresponsevalid;
    logic [1:0] writeresponse;

    // Request side belongs to the master
    modport master (
        output read, write, address, burstcount, writedata, byteenable,
        input waitrequest, readdata, readdatavalid, response,
        input writeresponsevalid, writeresponse
    );

    modport slave (
        input read, write, address, burstcount, writedata, byteenable,
        output waitrequest, readdata, readdatavalid, response,
        output writeresponsevalid, writeresponse
    );

endinterface

/* verilog/req_fifo2.sv */
`timescale 1ns/1ps

// Two-entry queue whose entry 0 is always the head
module req_fifo2 #(
    parameter int N_DATA_BITS = 32
) (
    input logic clk,
    input logic reset_n,
    input logic [N_DATA_BITS-1:0] enq_data,
    input logic enq_en,
    output logic not_full,
    output logic [N_DATA_BITS-1:0] first,
    input logic deq_en,
    output logic not_empty
);

    logic [N_DATA_BITS-1:0] data0;
    logic [N_DATA_BITS-1:0] data1;
    logic valid0;
    logic valid1;

    // Both flags come straight from the valid registers
    assign not_empty = valid0;
    assign not_full = !valid1;
    assign first = data0;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            valid0 <= 1'b0;
            valid1 <= 1'b0;
        end
        else if (enq_en && !deq_en)
        begin
            // New entry lands in the first free slot
            if (!valid0)
                valid0 <= 1'b1;
            else
                valid1 <= 1'b1;
        end
        else if (deq_en && !enq_en)
        begin
            // Second entry moves up to the head
            valid0 <= valid1;
            valid1 <= 1'b0;
        end
    end

    // Payload words shift toward the head as entries leave
    always_ff @(posedge clk)
    begin
        if (enq_en && deq_en)
        begin
            // Simultaneous pass-through keeps occupancy unchanged
            if (valid1)
            begin
                data0 <= data1;
                data1 <= enq_data;
            end
            else
            begin
                data0 <= enq_data;
            end
        end
        else if (enq_en)
        begin
            if (!valid0)
                data0 <= enq_data;
            else
                data1 <= enq_data;
        end
        else if (deq_en)
        begin
            data0 <= data1;
        end
    end

endmodule

/* verilog/rr_arbiter2.sv */
`timescale 1ns/1ps

// Round-robin choice between two clients
module rr_arbiter2 (
    input logic clk,
    input logic reset_n,
    input logic ena,
    input logic [1:0] request,
    output logic [1:0] grant
);

    // Index of the client that won last time
    logic last_winner;

    always_comb
    begin
        grant = 2'b00;
        // No grant at all while the arbiter is held off
        if (ena)
        begin
            if (last_winner == 1'b0)
            begin
                // Client 1 is next in line
                if (request[1])
                    grant = 2'b10;
                else if (request[0])
                    grant = 2'b01;
            end
            else
            begin
                if (request[0])
                    grant = 2'b01;
                else if (request[1])
                    grant = 2'b10;
            end
        end
    end

    // Priority rotates only when a grant actually goes out
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            last_winner <= 1'b1;
        else if (ena && (grant != 2'b00))
            last_winner <= grant[1];
    end

endmodule

/* verilog/wr_burst_tracker.sv */
`timescale 1ns/1ps

// Finds the final beat of each write burst on the master side
module wr_burst_tracker
    import avmm_pkg::*;
(
    input logic clk,
    input logic reset_n,
    input logic flit_valid,
    input logic [BURST_CNT_WIDTH-1:0] burstcount,
    output logic eop
);

    logic in_burst;
    logic [BURST_CNT_WIDTH-1:0] beats_left;
    logic [BURST_CNT_WIDTH-1:0] cur_count;

    // The first beat takes its count from the bus, later beats from the counter
    assign cur_count = in_burst ? beats_left : burstcount;
    assign eop = (cur_count == BURST_CNT_WIDTH'(1));

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            in_burst <= 1'b0;
            beats_left <= '0;
        end
        else if (flit_valid)
        begin
            in_burst <= !eop;
            beats_left <= cur_count - BURST_CNT_WIDTH'(1);
        end
    end

endmodule

/* verilog/avmm_rdwr_merge.sv */
`timescale 1ns/1ps

// Merges the split read and write channels onto one shared bus
module avmm_rdwr_merge
    import avmm_pkg::*;
(
    input logic clk,
    input logic reset_n,
    avmm_rdwr_if.slave mem_master,
    avmm_mem_if.master mem_slave
);

    rd_req_t rd_in;
    rd_req_t rd_head;
    wr_req_t wr_in;
    wr_req_t wr_head;
    logic rd_not_full;
    logic rd_not_empty;
    logic wr_not_full;
    logic wr_not_empty;
    logic rd_enq;
    logic wr_enq;
    logic wr_eop;
    logic [1:0] grant;
    logic burst_open;

    // Requests transfer whenever the queue has room
    assign mem_master.rd_waitrequest = !rd_not_full;
    assign mem_master.wr_waitrequest = !wr_not_full;
    assign rd_enq = mem_master.rd_read && !mem_master.rd_waitrequest;
    assign wr_enq = mem_master.wr_write && !mem_master.wr_waitrequest;

    always_comb
    begin
        rd_in.address = mem_master.rd_address;
        rd_in.burstcount = mem_master.rd_burstcount;
        rd_in.byteenable = mem_master.rd_byteenable;

        wr_in.address = mem_master.wr_address;
        wr_in.burstcount = mem_master.wr_burstcount;
        wr_in.data = mem_master.wr_writedata;
        wr_in.byteenable = mem_master.wr_byteenable;
        wr_in.eop = wr_eop;
    end

    // Tag each write beat as it is accepted so the output side knows
    // where a burst ends
    wr_burst_tracker i_wr_tracker (
        .clk        (clk),
        .reset_n    (reset_n),
        .flit_valid (wr_enq),
        .burstcount (mem_master.wr_burstcount),
        .eop        (wr_eop)
    );

    req_fifo2 #(
        .N_DATA_BITS ($bits(rd_req_t))
    ) i_rd_fifo (
        .clk       (clk),
        .reset_n   (reset_n),
        .enq_data  (rd_in),
        .enq_en    (rd_enq),
        .not_full  (rd_not_full),
        .first     (rd_head),
        .deq_en    (mem_slave.read),
        .not_empty (rd_not_empty)
    );

    req_fifo2 #(
        .N_DATA_BITS ($bits(wr_req_t))
    ) i_wr_fifo (
        .clk       (clk),
        .reset_n   (reset_n),
        .enq_data  (wr_in),
        .enq_en    (wr_enq),
        .not_full  (wr_not_full),
        .first     (wr_head),
        .deq_en    (mem_slave.write),
        .not_empty (wr_not_empty)
    );

    // Bit 0 is the read queue and bit 1 the write queue
    // An open write burst freezes arbitration until its last beat
    rr_arbiter2 i_arbiter (
        .clk     (clk),
        .reset_n (reset_n),
        .ena     (!mem_slave.waitrequest && !burst_open),
        .request ({wr_not_empty, rd_not_empty}),
        .grant   (grant)
    );

    assign mem_slave.read = grant[0];

    // Later beats of an open burst skip arbitration entirely
    assign mem_slave.write = grant[1] ||
                             (!mem_slave.waitrequest && burst_open && wr_not_empty);

    // Write is only raised with waitrequest low, so write means the beat is taken
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            burst_open <= 1'b0;
        else if (mem_slave.write)
            burst_open <= !wr_head.eop;
    end

    always_comb
    begin
        mem_slave.address = mem_slave.read ? rd_head.address : wr_head.address;
        mem_slave.burstcount = mem_slave.read ? rd_head.burstcount : wr_head.burstcount;
        mem_slave.byteenable = mem_slave.read ? rd_head.byteenable : wr_head.byteenable;
        mem_slave.writedata = wr_head.data;
    end

    // Responses go back untouched
    always_comb
    begin
        mem_master.rd_readdata = mem_slave.readdata;
        mem_master.rd_readdatavalid = mem_slave.readdatavalid;
        mem_master.rd_response = mem_slave.response;
        mem_master.wr_writeresponsevalid = mem_slave.writeresponsevalid;
        mem_master.wr_response = mem_slave.writeresponse;
    end

endmodule

/* verilog/burst_mem.sv */
`timescale 1ns/1ps

// Burst memory slave on the shared bus
module burst_mem
    import avmm_pkg::*;
(
    input logic clk,
    input logic reset_n,
    avmm_mem_if.slave mem
);

    logic [DATA_WIDTH-1:0] store [0:MEM_DEPTH-1];

    logic rd_start;
    logic rd_beat;
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic [ADDR_WIDTH-1:0] rd_beat_addr;
    logic [BURST_CNT_WIDTH-1:0] rd_left;
    logic rd_valid_q;

    logic wr_beat;
    logic wr_first;
    logic wr_last;
    logic wr_beat_err;
    logic [ADDR_WIDTH-1:0] wr_addr;
    logic [ADDR_WIDTH-1:0] wr_beat_addr;
    logic [BURST_CNT_WIDTH-1:0] wr_left;
    logic [BURST_CNT_WIDTH-1:0] wr_count;
    logic wr_err;
    logic wr_resp_valid_q;

    // The bus stalls for as long as read beats are streaming back
    assign mem.waitrequest = rd_valid_q;
    assign mem.readdatavalid = rd_valid_q;
    assign mem.writeresponsevalid = wr_resp_valid_q;

    // Beat 0 of a read uses the bus address so it returns in the next cycle
    assign rd_start = mem.read && !mem.waitrequest;
    assign rd_beat = rd_start || (rd_left != '0);
    assign rd_beat_addr = rd_start ? mem.address : rd_addr;

    // A write burst starts whenever no beats are outstanding
    assign wr_beat = mem.write && !mem.waitrequest;
    assign wr_first = (wr_left == '0);
    assign wr_count = wr_first ? mem.burstcount : wr_left;
    assign wr_last = (wr_count == BURST_CNT_WIDTH'(1));
    assign wr_beat_addr = wr_first ? mem.address : wr_addr;
    assign wr_beat_err = (wr_beat_addr >= ADDR_WIDTH'(MEM_DEPTH));

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_left <= '0;
            rd_valid_q <= 1'b0;
            wr_left <= '0;
            wr_resp_valid_q <= 1'b0;
        end
        else
        begin
            rd_valid_q <= rd_beat;
            // Count holds the beats still to be produced after this one
            if (rd_start)
                rd_left <= mem.burstcount - BURST_CNT_WIDTH'(1);
            else if (rd_left != '0)
                rd_left <= rd_left - BURST_CNT_WIDTH'(1);

            // One response per burst, in the cycle after its last beat
            wr_resp_valid_q <= wr_beat && wr_last;
            if (wr_beat)
                wr_left <= wr_count - BURST_CNT_WIDTH'(1);
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_beat)
        begin
            rd_addr <= rd_beat_addr + ADDR_WIDTH'(1);
            // Out of range words read back as zero with an error
            if (rd_beat_addr < ADDR_WIDTH'(MEM_DEPTH))
            begin
                mem.readdata <= store[rd_beat_addr[MEM_ADDR_WIDTH-1:0]];
                mem.response <= RESP_OKAY;
            end
            else
            begin
                mem.readdata <= '0;
                mem.response <= RESP_SLVERR;
            end
        end

        if (wr_beat)
        begin
            wr_addr <= wr_beat_addr + ADDR_WIDTH'(1);
            // Error accumulates across every beat of the burst
            wr_err <= (!wr_first && wr_err) || wr_beat_err;
            mem.writeresponse <= ((!wr_first && wr_err) || wr_beat_err) ?
                                 RESP_SLVERR : RESP_OKAY;
            if (!wr_beat_err)
            begin
                for (int i = 0; i < N_BYTES; i++)
                begin
                    if (mem.byteenable[i])
                        store[wr_beat_addr[MEM_ADDR_WIDTH-1:0]][8*i +: 8] <=
                            mem.writedata[8*i +: 8];
                end
            end
        end
    end

endmodule

/* verilog/avmm_rdwr_top.sv */
`timescale 1ns/1ps

// Split-bus bridge in front of the burst memory
module avmm_rdwr_top
    import avmm_pkg::*;
(
    input logic clk,
    input logic reset_n,

    input logic rd_read,
    input logic [ADDR_WIDTH-1:0] rd_address,
    input logic [BURST_CNT_WIDTH-1:0] rd_burstcount,
    input logic [N_BYTES-1:0] rd_byteenable,
    output logic rd_waitrequest,
    output logic [DATA_WIDTH-1:0] rd_readdata,
    output logic rd_readdatavalid,
    output logic [1:0] rd_response,

    input logic wr_write,
    input logic [ADDR_WIDTH-1:0] wr_address,
    input logic [BURST_CNT_WIDTH-1:0] wr_burstcount,
    input logic [DATA_WIDTH-1:0] wr_writedata,
    input logic [N_BYTES-1:0] wr_byteenable,
    output logic wr_waitrequest,
    output logic wr_writeresponsevalid,
    output logic [1:0] wr_response
);

    avmm_rdwr_if split_bus ();
    avmm_mem_if mem_bus ();

    // Requests go into the split interface
    assign split_bus.rd_read = rd_read;
    assign split_bus.rd_address = rd_address;
    assign split_bus.rd_burstcount = rd_burstcount;
    assign split_bus.rd_byteenable = rd_byteenable;
    assign split_bus.wr_write = wr_write;
    assign split_bus.wr_address = wr_address;
    assign split_bus.wr_burstcount = wr_burstcount;
    assign split_bus.wr_writedata = wr_writedata;
    assign split_bus.wr_byteenable = wr_byteenable;

    // Back-pressure and responses come back out
    assign rd_waitrequest = split_bus.rd_waitrequest;
    assign rd_readdata = split_bus.rd_readdata;
    assign rd_readdatavalid = split_bus.rd_readdatavalid;
    assign rd_response = split_bus.rd_response;
    assign wr_waitrequest = split_bus.wr_waitrequest;
    assign wr_writeresponsevalid = split_bus.wr_writeresponsevalid;
    assign wr_response = split_bus.wr_response;

    avmm_rdwr_merge i_merge (
        .clk        (clk),
        .reset_n    (reset_n),
        .mem_master (split_bus.slave),
        .mem_slave  (mem_bus.master)
    );

    burst_mem i_mem (
        .clk     (clk),
        .reset_n (reset_n),
        .mem     (mem_bus.slave)
    );

endmodule

/* tests/tb_avmm_rdwr_top.sv */
`timescale 1ns/1ps

// Testbench for the split-bus bridge with its burst memory behind it
module tb_avmm_rdwr_top
    import avmm_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 200;

    logic clk;
    logic reset_n;
    logic rd_read;
    logic [ADDR_WIDTH-1:0] rd_address;
    logic [BURST_CNT_WIDTH-1:0] rd_burstcount;
    logic [N_BYTES-1:0] rd_byteenable;
    logic rd_waitrequest;
    logic [DATA_WIDTH-1:0] rd_readdata;
    logic rd_readdatavalid;
    logic [1:0] rd_response;
    logic wr_write;
    logic [ADDR_WIDTH-1:0] wr_address;
    logic [BURST_CNT_WIDTH-1:0] wr_burstcount;
    logic [DATA_WIDTH-1:0] wr_writedata;
    logic [N_BYTES-1:0] wr_byteenable;
    logic wr_waitrequest;
    logic wr_writeresponsevalid;
    logic [1:0] wr_response;

    // Reference copy of the memory contents
    logic [DATA_WIDTH-1:0] shadow [0:MEM_DEPTH-1];

    // Responses still owed by the DUT, oldest first
    logic [DATA_WIDTH-1:0] exp_rd_data [$];
    logic [1:0] exp_rd_resp [$];
    logic [1:0] exp_wr_resp [$];

    int errors;
    int timeouts;
    int rd_beats_issued;
    int rd_beats_seen;
    int wr_bursts_issued;
    int wr_resps_seen;
    string test_name;

    avmm_rdwr_top i_dut (
        .clk                   (clk),
        .reset_n               (reset_n),
        .rd_read               (rd_read),
        .rd_address            (rd_address),
        .rd_burstcount         (rd_burstcount),
        .rd_byteenable         (rd_byteenable),
        .rd_waitrequest        (rd_waitrequest),
        .rd_readdata           (rd_readdata),
        .rd_readdatavalid      (rd_readdatavalid),
        .rd_response           (rd_response),
        .wr_write              (wr_write),
        .wr_address            (wr_address),
        .wr_burstcount         (wr_burstcount),
        .wr_writedata          (wr_writedata),
        .wr_byteenable         (wr_byteenable),
        .wr_waitrequest        (wr_waitrequest),
        .wr_writeresponsevalid (wr_writeresponsevalid),
        .wr_response           (wr_response)
    );

    always #4 clk = ~clk;

    // Once out of reset the handshake strobes must always be known
    assert property (@(posedge clk) disable iff (!reset_n)
        !$isunknown({rd_waitrequest, wr_waitrequest, rd_readdatavalid, wr_writeresponsevalid}))
    else
    begin
        errors++;
        $display("handshake strobes went unknown after reset");
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            errors++;
            $display("error %s %s: expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    // Pattern built from every address bit so aliased words differ
    function automatic logic [31:0] fill_word(input int addr);
        return 32'h5a00_0000 | (32'(addr) << 12) | 32'(addr);
    endfunction

    task automatic check_idle_outputs();
        check_value("rd_waitrequest", 32'd0, 32'(rd_waitrequest));
        check_value("wr_waitrequest", 32'd0, 32'(wr_waitrequest));
        check_value("rd_readdatavalid", 32'd0, 32'(rd_readdatavalid));
        check_value("wr_writeresponsevalid", 32'd0, 32'(wr_writeresponsevalid));
    endtask

    // Holds the current request until waitrequest is low ahead of an edge
    task automatic wait_accept(input bit is_write);
        int cycles;
        bit done;
        cycles = 0;
        done = 1'b0;
        while (!done && cycles < TIMEOUT_CYCLES)
        begin
            @(negedge clk);
            done = is_write ? !wr_waitrequest : !rd_waitrequest;
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!done)
        begin
            timeouts++;
            $display("timeout in %s: %s request was never accepted", test_name,
                     is_write ? "write" : "read");
        end
    endtask

    task automatic write_burst(input int addr, input int len, input bit use_fill,
                               input bit rand_be);
        int i;
        int a;
        int lane;
        logic [31:0] d;
        logic [3:0] be;
        bit err;
        err = 1'b0;
        wr_write = 1'b1;
        wr_address = ADDR_WIDTH'(addr);
        wr_burstcount = BURST_CNT_WIDTH'(len);
        for (i = 0; i < len; i++)
        begin
            a = addr + i;
            d = use_fill ? fill_word(a) : $urandom;
            be = rand_be ? 4'($urandom) : 4'hf;
            wr_writedata = d;
            wr_byteenable = be;
            wait_accept(1'b1);
            // Words past the end are dropped and flag the whole burst
            if (a < MEM_DEPTH)
            begin
                for (lane = 0; lane < N_BYTES; lane++)
                begin
                    if (be[lane])
                        shadow[a][8*lane +: 8] = d[8*lane +: 8];
                end
            end
            else
            begin
                err = 1'b1;
            end
        end
        exp_wr_resp.push_back(err ? RESP_SLVERR : RESP_OKAY);
        wr_bursts_issued++;
        wr_write = 1'b0;
    endtask

    task automatic read_burst(input int addr, input int len);
        int i;
        int a;
        rd_read = 1'b1;
        rd_address = ADDR_WIDTH'(addr);
        rd_burstcount = BURST_CNT_WIDTH'(len);
        rd_byteenable = 4'hf;
        wait_accept(1'b0);
        // Beats come back in address order after the request is taken
        for (i = 0; i < len; i++)
        begin
            a = addr + i;
            exp_rd_data.push_back(a < MEM_DEPTH ? shadow[a] : 32'd0);
            exp_rd_resp.push_back(a < MEM_DEPTH ? RESP_OKAY : RESP_SLVERR);
        end
        rd_beats_issued += len;
        rd_read = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while ((exp_rd_data.size() != 0 || exp_wr_resp.size() != 0) &&
               cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (exp_rd_data.size() != 0 || exp_wr_resp.size() != 0)
        begin
            timeouts++;
            $display("timeout in %s: %0d read beats and %0d write responses never came back",
                     test_name, exp_rd_data.size(), exp_wr_resp.size());
        end
    endtask

    // Every read beat is compared with the oldest expected word
    always @(negedge clk)
    begin
        if (reset_n && rd_readdatavalid)
        begin
            rd_beats_seen++;
            if (exp_rd_data.size() == 0)
            begin
                errors++;
                $display("read beat arrived in %s with no read outstanding", test_name);
            end
            else
            begin
                check_value("read data", exp_rd_data.pop_front(), rd_readdata);
                check_value("read response", 32'(exp_rd_resp.pop_front()), 32'(rd_response));
            end
        end
    end

    always @(negedge clk)
    begin
        if (reset_n && wr_writeresponsevalid)
        begin
            wr_resps_seen++;
            if (exp_wr_resp.size() == 0)
            begin
                errors++;
                $display("write response arrived in %s with no burst outstanding", test_name);
            end
            else
            begin
                check_value("write response", 32'(exp_wr_resp.pop_front()), 32'(wr_response));
            end
        end
    end

    initial
    begin
        int i;
        int a;
        int len;
        void'($urandom(32'hef29fea7));
        errors = 0;
        timeouts = 0;
        rd_beats_issued = 0;
        rd_beats_seen = 0;
        wr_bursts_issued = 0;
        wr_resps_seen = 0;
        clk = 1'b0;
        reset_n = 1'b0;
        rd_read = 1'b0;
        rd_address = '0;
        rd_burstcount = '0;
        rd_byteenable = '0;
        wr_write = 1'b0;
        wr_address = '0;
        wr_burstcount = '0;
        wr_writedata = '0;
        wr_byteenable = '0;

        // Outputs settle after the first reset edge, then stay quiet
        test_name = "reset";
        @(posedge clk);
        #1;
        for (i = 1; i < 16; i++)
        begin
            check_idle_outputs();
            @(posedge clk);
            #1;
        end
        reset_n = 1'b1;
        repeat (4)
        begin
            @(posedge clk);
            #1;
            check_idle_outputs();
        end

        // Known contents for every word that is read back later
        test_name = "fill";
        for (a = 0; a < 384; a += 4)
            write_burst(a, 4, 1'b1, 1'b0);
        wait_drain();

        test_name = "single";
        for (i = 0; i < 16; i++)
        begin
            a = $urandom % 256;
            write_burst(a, 1, 1'b0, 1'b1);
            wait_drain();
            read_burst(a, 1);
            wait_drain();
        end

        test_name = "burst";
        for (i = 0; i < 16; i++)
        begin
            len = 1 + (i % 4);
            a = 128 + ($urandom % 124);
            write_burst(a, len, 1'b0, 1'b1);
            wait_drain();
            read_burst(a, len);
            wait_drain();
        end

        // A burst across the top of the array and a write far past it
        test_name = "range";
        write_burst(510, 4, 1'b0, 1'b0);
        wait_drain();
        read_burst(510, 4);
        read_burst(0, 2);
        write_burst(700, 1, 1'b0, 1'b0);
        wait_drain();
        read_burst(700, 1);
        // Word 188 shares its low address bits with the dropped write
        read_burst(188, 1);
        wait_drain();

        // Both channels busy at once so the queues fill up
        test_name = "concurrent";
        fork
            begin
                int n;
                for (n = 0; n < 24; n++)
                    write_burst(256 + ($urandom % 124), 1 + ($urandom % 4), 1'b0, 1'b0);
            end
            begin
                int n;
                for (n = 0; n < 24; n++)
                    read_burst($urandom % 124, 1 + ($urandom % 4));
            end
        join
        wait_drain();
        // A split write burst would leave stray words in this region
        for (a = 256; a < 384; a += 4)
            read_burst(a, 4);
        wait_drain();

        test_name = "totals";
        check_value("read beats", 32'(rd_beats_issued), 32'(rd_beats_seen));
        check_value("write responses", 32'(wr_bursts_issued), 32'(wr_resps_seen));

        $display("run finished with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* src.f */
verilog/avmm_pkg.sv
verilog/avmm_rdwr_if.sv
verilog/avmm_mem_if.sv
verilog/req_fifo2.sv
verilog/rr_arbiter2.sv
verilog/wr_burst_tracker.sv
verilog/avmm_rdwr_merge.sv
verilog/burst_mem.sv
verilog/avmm_rdwr_top.sv
tests/tb_avmm_rdwr_top.sv

/* Bender.yml */
package:
  name: avmm_rdwr

sources:
  - verilog/avmm_pkg.sv
  - verilog/avmm_rdwr_if.sv
  - verilog/avmm_mem_if.sv
  - verilog/req_fifo2.sv
  - verilog/rr_arbiter2.sv
  - verilog/wr_burst_tracker.sv
  - verilog/avmm_rdwr_merge.sv
  - verilog/burst_mem.sv
  - verilog/avmm_rdwr_top.sv
  - target: test
    files:
      - tests/tb_avmm_rdwr_top.sv
